// ==== files.f ====
source/compress_pkg.sv
source/compress_ctrl.sv
source/coeff_reader.sv
source/coeff_compressor.sv
source/bit_packer.sv
source/api_mem_port.sv
source/compress_top.sv
tests/compress_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the compression engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wall -f files.f --top-module compress_tb -o compress_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/compress_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed"
    exit $status
fi
exit 0

// ==== source/api_mem_port.sv ====
/*
 * API memory port
 * Writes each packed word, or reads it back and compares in compare mode
 */

module api_mem_port (
    input  logic                            pi_clk,
    input  logic                            pi_reset_n,
    input  logic                            zeroize,
    input  logic                            start,
    input  logic                            word_valid,
    input  compress_pkg::job_t              job,
    input  logic [compress_pkg::data_w-1:0] word,
    input  logic [compress_pkg::data_w-1:0] api_rd_data,
    output compress_pkg::api_req_t          api_req,
    output logic                            compare_failed
);

    logic [compress_pkg::mem_addr_w-1:0] addr_q;
    logic                                check_q;
    logic [compress_pkg::data_w-1:0]     expect_q;

    // Read data arrives one cycle after the read request
    assign compare_failed = check_q && (api_rd_data != expect_q);

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            addr_q          <= '0;
            check_q         <= 1'b0;
            api_req.op      <= compress_pkg::api_idle;
            api_req.addr    <= '0;
            api_req.wr_data <= '0;
        end else if (zeroize) begin
            addr_q          <= '0;
            check_q         <= 1'b0;
            api_req.op      <= compress_pkg::api_idle;
            api_req.addr    <= '0;
            api_req.wr_data <= '0;
        end else begin
            if (start) begin
                addr_q <= job.dest_base;
            end else if (word_valid) begin
                addr_q <= addr_q + 1'b1;
            end

            if (word_valid) begin
                api_req.op <= job.compare ? compress_pkg::api_read : compress_pkg::api_write;
                api_req.addr    <= addr_q;
                // On a read this carries the expected word
                api_req.wr_data <= word;
            end else begin
                api_req.op <= compress_pkg::api_idle;
            end

            check_q <= api_req.op == compress_pkg::api_read;
        end
    end

    always_ff @(posedge pi_clk) begin
        expect_q <= api_req.wr_data;
    end

endmodule

// ==== source/bit_packer.sv ====
/*
 * Packing buffer
 * Appends compressed groups LSB first and drains 32-bit words
 * Room is raised while the next cycle's fill leaves space for a full group
 */

module bit_packer (
    input  logic                                    pi_clk,
    input  logic                                    pi_reset_n,
    input  logic                                    zeroize,
    input  logic                                    start,
    input  logic                                    resp_valid,
    input  compress_pkg::job_t                      job,
    input  logic [compress_pkg::group_bits_max-1:0] group_data,
    output logic                                    word_valid,
    output logic [compress_pkg::data_w-1:0]         word,
    output logic                                    room
);

    compress_pkg::occ_t occ_q;
    compress_pkg::occ_t occ_shift;
    compress_pkg::occ_t occ_next;
    compress_pkg::occ_t group_bits;
    compress_pkg::buf_t buf_q;
    compress_pkg::buf_t buf_shift;
    compress_pkg::buf_t buf_next;
    compress_pkg::buf_t keep_mask;

    assign group_bits = compress_pkg::occ_t'(compress_pkg::coeff_per_clk)
                      * compress_pkg::occ_t'(compress_pkg::mode_bits(job.mode));

    // Drain from the registered fill level
    assign word_valid = occ_q >= compress_pkg::occ_t'(compress_pkg::data_w);
    assign word       = buf_q[compress_pkg::data_w-1:0];

    always_comb begin
        if (word_valid) begin
            buf_shift = buf_q >> compress_pkg::data_w;
            occ_shift = occ_q - compress_pkg::occ_t'(compress_pkg::data_w);
        end else begin
            buf_shift = buf_q;
            occ_shift = occ_q;
        end

        // Bits above the fill level are stale
        keep_mask = ~compress_pkg::buf_t'(0)
                  >> (compress_pkg::occ_t'(compress_pkg::buf_bits) - occ_shift);

        buf_next = buf_shift;
        occ_next = occ_shift;
        if (resp_valid) begin
            buf_next = (buf_shift & keep_mask)
                     | (compress_pkg::buf_t'(group_data) << occ_shift);
            occ_next = occ_shift + group_bits;
        end
    end

    // Same threshold for every mode
    assign room = occ_next <= compress_pkg::occ_t'(compress_pkg::buf_bits
                                                   - compress_pkg::group_bits_max);

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            occ_q <= '0;
        end else if (zeroize || start) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_next;
        end
    end

    always_ff @(posedge pi_clk) begin
        buf_q <= buf_next;
    end

endmodule

// ==== source/coeff_compressor.sv ====
/*
 * Coefficient compression
 * round(x * 2^d / Q) mod 2^d on four lanes, packed lane 0 lowest
 */

module coeff_compressor (
    input  compress_pkg::job_t  job,
    input  logic [compress_pkg::coeff_per_clk-1:0][compress_pkg::coeff_w-1:0] mem_rd_data,
    output logic [compress_pkg::group_bits_max-1:0] group_data
);

    logic [3:0]                       d;
    logic [compress_pkg::coeff_w-1:0] lane_mask;
    compress_pkg::prod_t              scaled   [compress_pkg::coeff_per_clk];
    compress_pkg::prod_t              quotient [compress_pkg::coeff_per_clk];
    logic [compress_pkg::coeff_w-1:0] lane_val [compress_pkg::coeff_per_clk];

    assign d         = compress_pkg::mode_bits(job.mode);
    assign lane_mask = (compress_pkg::coeff_w'(1) << d) - 1'b1;

    always_comb begin
        for (int i = 0; i < compress_pkg::coeff_per_clk; i++) begin
            // Adding Q/2 before the divide rounds to nearest
            scaled[i]   = (compress_pkg::prod_t'(mem_rd_data[i]) << d)
                        + compress_pkg::prod_t'(compress_pkg::mlkem_q / 2);
            quotient[i] = scaled[i] / compress_pkg::prod_t'(compress_pkg::mlkem_q);
            if (job.mode == compress_pkg::compress12) begin
                lane_val[i] = mem_rd_data[i];
            end else begin
                lane_val[i] = quotient[i][compress_pkg::coeff_w-1:0] & lane_mask;
            end
        end
    end

    ////////////////////
    // Lane packing

    always_comb begin
        group_data = '0;
        for (int i = 0; i < compress_pkg::coeff_per_clk; i++) begin
            group_data = group_data | (compress_pkg::group_t'(lane_val[i]) << (i * d));
        end
    end

endmodule

// ==== source/coeff_reader.sv ====
/*
 * Source memory read sequencer
 * Issues consecutive reads from src_base while the packer has room
 */

module coeff_reader (
    input  logic                   pi_clk,
    input  logic                   pi_reset_n,
    input  logic                   zeroize,
    input  logic                   start,
    input  compress_pkg::job_t     job,
    input  logic                   room,
    output compress_pkg::mem_req_t mem_rd_req
);

    logic                                active_q;
    logic                                issue;
    logic [compress_pkg::mem_addr_w-1:0] addr_q;
    logic [compress_pkg::mem_addr_w-1:0] cur_addr;
    compress_pkg::read_cnt_t             cnt_q;
    compress_pkg::read_cnt_t             cur_cnt;
    compress_pkg::read_cnt_t             read_total;

    assign read_total = compress_pkg::read_cnt_t'(job.num_poly)
                      * compress_pkg::read_cnt_t'(compress_pkg::reads_per_poly);

    // First read goes out in the start cycle itself
    assign cur_addr = start ? job.src_base : addr_q;
    assign cur_cnt  = start ? '0 : cnt_q;
    assign issue    = (start || active_q) && room;

    assign mem_rd_req.rd_en = issue;
    assign mem_rd_req.addr  = cur_addr;

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            active_q <= 1'b0;
            addr_q   <= '0;
            cnt_q    <= '0;
        end else if (zeroize) begin
            active_q <= 1'b0;
            addr_q   <= '0;
            cnt_q    <= '0;
        end else if (issue) begin
            addr_q   <= cur_addr + 1'b1;
            cnt_q    <= cur_cnt + 1'b1;
            // Stop after the last read of the last polynomial
            active_q <= (cur_cnt + 1'b1) != read_total;
        end else if (start) begin
            // Held on the first cycle, keep the base for later
            addr_q   <= job.src_base;
            cnt_q    <= '0;
            active_q <= 1'b1;
        end
    end

endmodule

// ==== source/compress_ctrl.sv ====
/*
 * Compression job control
 * Captures the job, counts emitted words and pulses done
 */

module compress_ctrl (
    input  logic               pi_clk,
    input  logic               pi_reset_n,
    input  logic               zeroize,
    input  logic               compress_enable,
    input  compress_pkg::job_t job_in,
    input  logic               word_valid,
    output compress_pkg::job_t job,
    output logic               start,
    output logic               busy,
    output logic               compress_done
);

    logic                   accept;
    logic                   last_word_q;
    compress_pkg::word_cnt_t word_cnt_q;
    compress_pkg::word_cnt_t word_total;

    // New jobs only while idle
    assign accept = compress_enable && !busy;

    // num_poly x 8 x bits per coefficient
    assign word_total = compress_pkg::word_cnt_t'(job.num_poly)
                      * compress_pkg::word_cnt_t'(compress_pkg::words_per_bit)
                      * compress_pkg::word_cnt_t'(compress_pkg::mode_bits(job.mode));

    // Job configuration
    always_ff @(posedge pi_clk) begin
        if (accept) begin
            job <= job_in;
        end
    end

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            busy          <= 1'b0;
            start         <= 1'b0;
            word_cnt_q    <= '0;
            last_word_q   <= 1'b0;
            compress_done <= 1'b0;
        end else if (zeroize) begin
            busy          <= 1'b0;
            start         <= 1'b0;
            word_cnt_q    <= '0;
            last_word_q   <= 1'b0;
            compress_done <= 1'b0;
        end else begin
            start <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (compress_done) begin
                busy <= 1'b0;
            end
            if (accept) begin
                word_cnt_q <= '0;
            end else if (word_valid) begin
                word_cnt_q <= word_cnt_q + 1'b1;
            end
            // Final word seen, its API request follows one cycle later
            last_word_q   <= busy && word_valid && (word_cnt_q == word_total - 1'b1);
            compress_done <= last_word_q;
        end
    end

endmodule

// ==== source/compress_pkg.sv ====
/*
 * ML-KEM compression engine shared definitions
 * Constants, mode encoding, job and memory request structs
 */

package compress_pkg;

    ////////////////////
    // Constants

    localparam int mlkem_q        = 3329;
    localparam int coeff_w        = 12;
    localparam int coeff_per_clk  = 4;
    localparam int reads_per_poly = 64;
    localparam int mem_addr_w     = 15;
    localparam int data_w         = 32;
    localparam int buf_bits       = 96;
    localparam int group_bits_max = 48;

    // Largest job is 7 polynomials
    localparam int max_poly       = 7;
    // Words per polynomial for each bit of compressed width
    localparam int words_per_bit  = reads_per_poly * coeff_per_clk / data_w;
    localparam int read_cnt_w     = $clog2(max_poly * reads_per_poly + 1);
    localparam int word_cnt_w     = $clog2(max_poly * words_per_bit * coeff_w + 1);
    localparam int occ_w          = $clog2(buf_bits + 1);

    typedef logic [read_cnt_w-1:0]     read_cnt_t;
    typedef logic [word_cnt_w-1:0]     word_cnt_t;
    typedef logic [occ_w-1:0]          occ_t;
    typedef logic [2*coeff_w-1:0]      prod_t;
    typedef logic [group_bits_max-1:0] group_t;
    typedef logic [buf_bits-1:0]       buf_t;

    ////////////////////
    // Types

    typedef enum logic [1:0] {
        compress1  = 2'b00,
        compress5  = 2'b01,
        compress11 = 2'b10,
        compress12 = 2'b11
    } compress_mode_t;

    typedef struct packed {
        compress_mode_t        mode;
        logic                  compare;
        logic [2:0]            num_poly;
        logic [mem_addr_w-1:0] src_base;
        logic [mem_addr_w-1:0] dest_base;
    } job_t;

    typedef struct packed {
        logic                  rd_en;
        logic [mem_addr_w-1:0] addr;
    } mem_req_t;

    typedef enum logic [1:0] {
        api_idle  = 2'b00,
        api_write = 2'b01,
        api_read  = 2'b10
    } api_op_t;

    typedef struct packed {
        api_op_t               op;
        logic [mem_addr_w-1:0] addr;
        logic [data_w-1:0]     wr_data;
    } api_req_t;

    // Bits kept per coefficient
    function automatic logic [3:0] mode_bits(compress_mode_t mode);
        case (mode)
            compress1:  return 4'd1;
            compress5:  return 4'd5;
            compress11: return 4'd11;
            default:    return 4'd12;
        endcase
    endfunction

endpackage

// ==== source/compress_top.sv ====
/*
 * ML-KEM coefficient compression engine
 * Reader, compressor, packer and API port in one pipeline
 */

module compress_top (
    input  logic                   pi_clk,
    input  logic                   pi_reset_n,
    input  logic                   zeroize,
    input  logic                   compress_enable,
    input  compress_pkg::job_t     job,
    output compress_pkg::mem_req_t mem_rd_req,
    input  logic [compress_pkg::coeff_per_clk-1:0][compress_pkg::coeff_w-1:0] mem_rd_data,
    output compress_pkg::api_req_t api_req,
    input  logic [compress_pkg::data_w-1:0] api_rd_data,
    output logic                   compare_failed,
    output logic                   compress_done
);

    compress_pkg::job_t                      job_cfg;
    logic                                    start;
    logic                                    busy;
    logic                                    room;
    logic                                    resp_valid;
    logic [compress_pkg::group_bits_max-1:0] group_data;
    logic                                    word_valid;
    logic [compress_pkg::data_w-1:0]         word;

    compress_ctrl i_compress_ctrl (
        .pi_clk          (pi_clk),
        .pi_reset_n      (pi_reset_n),
        .zeroize         (zeroize),
        .compress_enable (compress_enable),
        .job_in          (job),
        .word_valid      (word_valid),
        .job             (job_cfg),
        .start           (start),
        .busy            (busy),
        .compress_done   (compress_done)
    );

    coeff_reader i_coeff_reader (
        .pi_clk     (pi_clk),
        .pi_reset_n (pi_reset_n),
        .zeroize    (zeroize),
        .start      (start),
        .job        (job_cfg),
        .room       (room),
        .mem_rd_req (mem_rd_req)
    );

    ////////////////////
    // Source memory has a fixed one-cycle latency

    always_ff @(posedge pi_clk or negedge pi_reset_n) begin
        if (!pi_reset_n) begin
            resp_valid <= 1'b0;
        end else if (zeroize) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= mem_rd_req.rd_en && busy;
        end
    end

    coeff_compressor i_coeff_compressor (
        .job         (job_cfg),
        .mem_rd_data (mem_rd_data),
        .group_data  (group_data)
    );

    bit_packer i_bit_packer (
        .pi_clk     (pi_clk),
        .pi_reset_n (pi_reset_n),
        .zeroize    (zeroize),
        .start      (start),
        .resp_valid (resp_valid),
        .job        (job_cfg),
        .group_data (group_data),
        .word_valid (word_valid),
        .word       (word),
        .room       (room)
    );

    api_mem_port i_api_mem_port (
        .pi_clk         (pi_clk),
        .pi_reset_n     (pi_reset_n),
        .zeroize        (zeroize),
        .start          (start),
        .word_valid     (word_valid),
        .job            (job_cfg),
        .word           (word),
        .api_rd_data    (api_rd_data),
        .api_req        (api_req),
        .compare_failed (compare_failed)
    );

endmodule

// ==== tests/compress_tb.sv ====
/*
 * Testbench for the ML-KEM compression engine
 * Memory models, reference packing model, job stimulus and checks
 */

module compress_tb;

    localparam int num_jobs  = 6;
    localparam int zero_job  = 4;
    localparam int mem_depth = 1 << compress_pkg::mem_addr_w;

    logic                   pi_clk;
    logic                   pi_reset_n;
    logic                   zeroize;
    logic                   compress_enable;
    compress_pkg::job_t     job;
    compress_pkg::mem_req_t mem_rd_req;
    logic [compress_pkg::coeff_per_clk-1:0][compress_pkg::coeff_w-1:0] mem_rd_data;
    compress_pkg::api_req_t api_req;
    logic [31:0]            api_rd_data;
    logic                   compare_failed;
    logic                   compress_done;

    logic [47:0] src_mem [mem_depth];
    logic [31:0] api_mem [mem_depth];
    logic [31:0] exp_words [$];

    int job_mode [num_jobs] = '{1, 5, 11, 12, 11, 12};
    int job_np   [num_jobs] = '{1, 2, 3, 1, 2, 2};
    int job_cmp  [num_jobs] = '{0, 1, 0, 1, 0, 0};
    int job_src  [num_jobs] = '{16, 300, 1000, 5000, 7000, 9000};
    int job_dest [num_jobs] = '{40, 2000, 3000, 12000, 20000, 30000};

    // Job parameters seen by the monitor
    int cur_src;
    int cur_dest;
    int cur_cmp;
    int n_reads;
    int n_words;
    int corrupt_idx;

    // Monitor state
    bit active;
    int rd_idx;
    int api_idx;
    int done_count;
    bit cf_expect;
    bit done_expect;
    int cycle;
    int limit;

    compress_top i_compress_top (
        .pi_clk          (pi_clk),
        .pi_reset_n      (pi_reset_n),
        .zeroize         (zeroize),
        .compress_enable (compress_enable),
        .job             (job),
        .mem_rd_req      (mem_rd_req),
        .mem_rd_data     (mem_rd_data),
        .api_req         (api_req),
        .api_rd_data     (api_rd_data),
        .compare_failed  (compare_failed),
        .compress_done   (compress_done)
    );

    initial pi_clk = 1'b0;
    always #20 pi_clk = ~pi_clk;

    ////////////////////
    // Helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // Round half up of x * 2^d / Q, taken mod 2^d
    function automatic int compress_coeff(input int x, input int d);
        if (d == 12) begin
            return x;
        end
        return (((x << (d + 1)) + 3329) / (2 * 3329)) % (1 << d);
    endfunction

    task automatic report_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "check failed");
    endtask

    task automatic build_expected(input int src, input int np, input int d);
        bit          bits [$];
        int          v;
        logic [31:0] w;
        exp_words.delete();
        for (int r = 0; r < np * 64; r++) begin
            for (int l = 0; l < 4; l++) begin
                v = compress_coeff(int'(src_mem[src + r][12*l +: 12]), d);
                for (int b = 0; b < d; b++) begin
                    bits.push_back(v[b]);
                end
            end
        end
        while (bits.size() >= 32) begin
            for (int b = 0; b < 32; b++) begin
                w[b] = bits.pop_front();
            end
            exp_words.push_back(w);
        end
    endtask

    ////////////////////
    // Memory models

    always @(posedge pi_clk) begin
        if (mem_rd_req.rd_en) begin
            mem_rd_data <= src_mem[mem_rd_req.addr];
        end
        if (api_req.op == compress_pkg::api_write) begin
            api_mem[api_req.addr] <= api_req.wr_data;
        end
        if (api_req.op == compress_pkg::api_read) begin
            api_rd_data <= api_mem[api_req.addr];
        end
    end

    ////////////////////
    // Monitor and checks

    always @(posedge pi_clk) begin
        if (pi_reset_n) begin
            assert (compare_failed == cf_expect) else report_fail("compare_failed timing");
            assert (compress_done == done_expect) else report_fail("compress_done timing");
            cf_expect   = 1'b0;
            done_expect = 1'b0;
            if (mem_rd_req.rd_en) begin
                assert (active && rd_idx < n_reads) else report_fail("read outside a job");
                assert (int'(mem_rd_req.addr) == cur_src + rd_idx)
                    else report_fail("wrong read address");
                rd_idx++;
            end
            if (api_req.op != compress_pkg::api_idle) begin
                assert (active && api_idx < n_words) else report_fail("API request outside job");
                assert (api_req.op == (cur_cmp ? compress_pkg::api_read : compress_pkg::api_write))
                    else report_fail("wrong API operation");
                assert (int'(api_req.addr) == cur_dest + api_idx)
                    else report_fail("wrong API address");
                if (!cur_cmp) begin
                    assert (api_req.wr_data == exp_words[api_idx])
                        else report_fail("wrong write data");
                end
                cf_expect   = cur_cmp && (api_idx == corrupt_idx);
                done_expect = (api_idx == n_words - 1);
                api_idx++;
            end
            if (compress_done) begin
                assert (rd_idx == n_reads && api_idx == n_words)
                    else report_fail("done before all reads and words");
                active = 1'b0;
                done_count++;
            end
            if (compress_enable) begin
                active  = 1'b1;
                rd_idx  = 0;
                api_idx = 0;
            end
            if (zeroize) begin
                active      = 1'b0;
                cf_expect   = 1'b0;
                done_expect = 1'b0;
            end
        end
    end

    // Run limit
    always @(posedge pi_clk) begin
        cycle++;
        if (cycle >= limit) begin
            $display("Timeout after %0d cycles, a job did not finish", cycle);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // Stimulus

    task automatic run_job(input int j);
        int target;
        cur_src  = job_src[j];
        cur_dest = job_dest[j];
        cur_cmp  = job_cmp[j];
        n_reads  = job_np[j] * 64;
        build_expected(cur_src, job_np[j], job_mode[j]);
        n_words     = exp_words.size();
        corrupt_idx = n_words / 2;
        if (cur_cmp) begin
            for (int k = 0; k < n_words; k++) begin
                api_mem[cur_dest + k] <= (k == corrupt_idx) ? ~exp_words[k] : exp_words[k];
            end
        end
        job.mode      = compress_pkg::compress_mode_t'((job_mode[j] == 1) ? 0 :
                        (job_mode[j] == 5) ? 1 : (job_mode[j] == 11) ? 2 : 3);
        job.compare   = cur_cmp[0];
        job.num_poly  = job_np[j][2:0];
        job.src_base  = cur_src[14:0];
        job.dest_base = cur_dest[14:0];
        compress_enable = 1'b1;
        @(posedge pi_clk);
        #5;
        compress_enable = 1'b0;
        if (j == zero_job) begin
            while (api_idx < 10) begin
                @(posedge pi_clk);
            end
            #5;
            zeroize = 1'b1;
            @(posedge pi_clk);
            #5;
            zeroize = 1'b0;
            assert (!mem_rd_req.rd_en && api_req.op == compress_pkg::api_idle
                    && !compare_failed && !compress_done)
                else report_fail("outputs active after zeroize");
        end else begin
            target = done_count + 1;
            while (done_count < target) begin
                @(posedge pi_clk);
            end
            #5;
        end
        repeat (3) @(posedge pi_clk);
        #5;
    endtask

    initial begin
        logic [31:0] s;
        s = 32'h3383;
        for (int a = 0; a < mem_depth; a++) begin
            for (int l = 0; l < 4; l++) begin
                int v;
                v = 0;
                for (int b = 0; b < 12; b++) begin
                    s = lfsr_step(s);
                    v = v | (int'(s[0]) << b);
                end
                src_mem[a][12*l +: 12] = 12'(v % compress_pkg::mlkem_q);
            end
            api_mem[a] <= 32'h0;
        end
        limit = 0;
        for (int j = 0; j < num_jobs; j++) begin
            limit += (job_np[j] * 64 + job_np[j] * 8 * job_mode[j]) * 4;
        end
        pi_reset_n      = 1'b0;
        zeroize         = 1'b0;
        compress_enable = 1'b0;
        job             = '0;
        mem_rd_data     <= '0;
        api_rd_data     <= '0;
        repeat (8) @(posedge pi_clk);
        #5;
        pi_reset_n = 1'b1;
        repeat (2) @(posedge pi_clk);
        #5;
        for (int j = 0; j < num_jobs; j++) begin
            run_job(j);
        end
        $display("No errors");
        $finish;
    end

endmodule
